//--- rtl/sma_pkg.sv
package sma_pkg;

	// apb address bus width, byte addresses
	localparam int SMA_APB_AW = 4;

	// width of the window exponent field
	localparam int SMA_WIN_W = 4;

	// bit positions inside the registers
	localparam int CTRL_EN_BIT = 0;
	localparam int STATUS_BUSY_BIT = 0;

	// controller states
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_CLEAR = 2'd1,
		ST_RUN   = 2'd2
	} sma_state_e;

	// register word addresses
	typedef enum logic [SMA_APB_AW-1:0] {
		REG_CTRL   = 4'h0,
		REG_WINDOW = 4'h4,
		REG_STATUS = 4'h8,
		REG_AVG    = 4'hC
	} sma_reg_e;

endpackage

//--- rtl/sma_hist_if.sv
interface sma_hist_if #(
	parameter int DATA_W = 32,
	parameter int MAX_LOG2 = 8
);

	logic wr_en;
	logic [MAX_LOG2-1:0] wr_addr;
	logic [DATA_W-1:0] wr_data;
	logic [MAX_LOG2-1:0] rd_addr;
	logic [DATA_W-1:0] rd_data;
	// sample entering the running sum
	logic accept;
	// hold the sum at zero
	logic clear;

	modport ctrl (output wr_en, wr_addr, wr_data, rd_addr, accept, clear);
	modport mem (input wr_en, wr_addr, wr_data, rd_addr, output rd_data);
	modport acc (input accept, wr_data, rd_data, clear);

endinterface

//--- rtl/sma_apb_regs.sv
module sma_apb_regs import sma_pkg::*; #(
	parameter int DATA_W = 32,
	parameter int MAX_LOG2 = 8
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_psel,
	input  logic i_penable,
	input  logic i_pwrite,
	input  logic [SMA_APB_AW-1:0] i_paddr,
	input  logic [DATA_W-1:0] i_pwdata,
	input  logic i_busy,
	input  logic [DATA_W-1:0] i_avg,
	output logic [DATA_W-1:0] o_prdata,
	output logic o_pready,
	output logic o_pslverr,
	output logic o_enable,
	output logic [SMA_WIN_W-1:0] o_window,
	output logic o_window_wr
);

	localparam logic [SMA_WIN_W-1:0] K_MAX = SMA_WIN_W'(MAX_LOG2);

	sma_reg_e addr;
	logic access;
	logic addr_ok;
	logic read_only;
	logic wr_ok;
	logic [DATA_W-1:0] rdata;
	logic [SMA_WIN_W-1:0] k_in;
	logic enable_q;
	logic [SMA_WIN_W-1:0] window_q;
	logic window_wr_q;

	assign addr = sma_reg_e'(i_paddr);
	assign access = i_psel && i_penable;
	assign k_in = i_pwdata[SMA_WIN_W-1:0];

	// register decode and read mux
	always_comb begin
		rdata = '0;
		addr_ok = 1'b1;
		read_only = 1'b0;
		case (addr)
			REG_CTRL: rdata[CTRL_EN_BIT] = enable_q;
			REG_WINDOW: rdata[SMA_WIN_W-1:0] = window_q;
			REG_STATUS: begin
				rdata[STATUS_BUSY_BIT] = i_busy;
				read_only = 1'b1;
			end
			REG_AVG: begin
				rdata = i_avg;
				read_only = 1'b1;
			end
			default: addr_ok = 1'b0;
		endcase
	end

	// no wait states
	assign o_pready = 1'b1;
	assign o_pslverr = access && (!addr_ok || (i_pwrite && read_only));
	assign o_prdata = (access && !i_pwrite) ? rdata : '0;
	assign wr_ok = access && i_pwrite && addr_ok && !read_only;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			enable_q <= 1'b0;
			window_q <= '0;
			window_wr_q <= 1'b0;
		end else begin
			window_wr_q <= wr_ok && (addr == REG_WINDOW);
			if (wr_ok && (addr == REG_CTRL))
				enable_q <= i_pwdata[CTRL_EN_BIT];
			// oversized exponents saturate
			if (wr_ok && (addr == REG_WINDOW))
				window_q <= (k_in > K_MAX) ? K_MAX : k_in;
		end
	end

	assign o_enable = enable_q;
	assign o_window = window_q;
	assign o_window_wr = window_wr_q;

	// an error only ends a transfer that had its setup phase
	a_pslverr_access: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_pslverr |-> i_penable && $past(i_psel && !i_penable));

endmodule

//--- rtl/sma_ctrl.sv
module sma_ctrl import sma_pkg::*; #(
	parameter int DATA_W = 32,
	parameter int MAX_LOG2 = 8
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_enable,
	input  logic [SMA_WIN_W-1:0] i_window,
	input  logic i_window_wr,
	input  logic i_sample_valid,
	input  logic [DATA_W-1:0] i_sample,
	output logic o_sample_ready,
	output logic o_busy,
	sma_hist_if.ctrl hist
);

	sma_state_e state_q;
	// ring pointer, doubles as the clear counter
	logic [MAX_LOG2-1:0] ptr_q;
	logic [MAX_LOG2-1:0] win_mask;
	logic sample_ready;
	logic accept;
	logic clearing;

	assign clearing = (state_q == ST_CLEAR);
	assign sample_ready = i_enable && (state_q == ST_RUN);
	assign accept = sample_ready && i_sample_valid;

	// low k bits set, pointer wraps at 2^k
	assign win_mask = ~({MAX_LOG2{1'b1}} << i_window);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q <= ST_IDLE;
			ptr_q <= '0;
		end else if (i_window_wr) begin
			// new window, restart the clear
			state_q <= ST_CLEAR;
			ptr_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					state_q <= ST_CLEAR;
					ptr_q <= '0;
				end
				ST_CLEAR: begin
					// walks the full depth and wraps back to 0
					ptr_q <= ptr_q + 1'b1;
					if (&ptr_q)
						state_q <= ST_RUN;
				end
				ST_RUN: begin
					if (accept)
						ptr_q <= (ptr_q + 1'b1) & win_mask;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	assign o_sample_ready = sample_ready;
	assign o_busy = clearing;

	// zeros while clearing, samples while running
	assign hist.wr_en = clearing || accept;
	assign hist.wr_addr = ptr_q;
	assign hist.wr_data = clearing ? '0 : i_sample;
	assign hist.rd_addr = ptr_q;
	assign hist.accept = accept;
	assign hist.clear = clearing;

	// pointer stays inside the active window between window changes
	a_ptr_in_window: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(state_q == ST_RUN && !i_window_wr) |-> ((ptr_q & ~win_mask) == '0));

endmodule

//--- rtl/sma_history.sv
module sma_history #(
	parameter int DATA_W = 32,
	parameter int MAX_LOG2 = 8
) (
	input logic i_clk,
	sma_hist_if.mem mem
);

	localparam int DEPTH = 1 << MAX_LOG2;

	// sample ring, zeroed by the clear sweep
	logic [DATA_W-1:0] ring [DEPTH];

	always_ff @(posedge i_clk) begin
		if (mem.wr_en)
			ring[mem.wr_addr] <= mem.wr_data;
	end

	// outgoing entry, old value until the write edge
	assign mem.rd_data = ring[mem.rd_addr];

endmodule

//--- rtl/sma_accum.sv
module sma_accum import sma_pkg::*; #(
	parameter int DATA_W = 32,
	parameter int MAX_LOG2 = 8
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic [SMA_WIN_W-1:0] i_window,
	sma_hist_if.acc acc,
	output logic o_avg_valid,
	output logic signed [DATA_W-1:0] o_avg
);

	// room for 2^MAX_LOG2 full-scale samples
	localparam int SUM_W = DATA_W + MAX_LOG2;

	logic signed [SUM_W-1:0] sum_q;
	logic signed [SUM_W-1:0] new_ext;
	logic signed [SUM_W-1:0] old_ext;
	logic signed [SUM_W-1:0] sum_d;
	logic signed [SUM_W-1:0] scaled;
	logic signed [DATA_W-1:0] avg_q;
	logic avg_valid_q;

	assign new_ext = {{MAX_LOG2{acc.wr_data[DATA_W-1]}}, acc.wr_data};
	assign old_ext = {{MAX_LOG2{acc.rd_data[DATA_W-1]}}, acc.rd_data};
	assign sum_d = sum_q + new_ext - old_ext;

	// arithmetic shift, floor of sum / 2^k
	assign scaled = sum_d >>> i_window;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sum_q <= '0;
			avg_q <= '0;
			avg_valid_q <= 1'b0;
		end else begin
			avg_valid_q <= acc.accept;
			if (acc.clear)
				sum_q <= '0;
			else if (acc.accept) begin
				sum_q <= sum_d;
				avg_q <= scaled[DATA_W-1:0];
			end
		end
	end

	assign o_avg_valid = avg_valid_q;
	assign o_avg = avg_q;

	// controller never accepts while it zeroes the history
	a_accept_clear: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(acc.accept && acc.clear));

endmodule

//--- rtl/sma_top.sv
module sma_top import sma_pkg::*; #(
	parameter int DATA_W = 32,
	parameter int MAX_LOG2 = 8
) (
	input  logic i_clk,
	input  logic i_rst_n,
	// apb3 slave
	input  logic i_psel,
	input  logic i_penable,
	input  logic i_pwrite,
	input  logic [SMA_APB_AW-1:0] i_paddr,
	input  logic [DATA_W-1:0] i_pwdata,
	output logic [DATA_W-1:0] o_prdata,
	output logic o_pready,
	output logic o_pslverr,
	// sample stream
	input  logic i_sample_valid,
	input  logic signed [DATA_W-1:0] i_sample,
	output logic o_sample_ready,
	// result
	output logic o_avg_valid,
	output logic signed [DATA_W-1:0] o_avg
);

	logic enable;
	logic [SMA_WIN_W-1:0] window;
	logic window_wr;
	logic busy;

	sma_hist_if #(.DATA_W(DATA_W), .MAX_LOG2(MAX_LOG2)) hist ();

	sma_apb_regs #(.DATA_W(DATA_W), .MAX_LOG2(MAX_LOG2)) i_sma_apb_regs (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_psel      (i_psel),
		.i_penable   (i_penable),
		.i_pwrite    (i_pwrite),
		.i_paddr     (i_paddr),
		.i_pwdata    (i_pwdata),
		.i_busy      (busy),
		.i_avg       (o_avg),
		.o_prdata    (o_prdata),
		.o_pready    (o_pready),
		.o_pslverr   (o_pslverr),
		.o_enable    (enable),
		.o_window    (window),
		.o_window_wr (window_wr)
	);

	sma_ctrl #(.DATA_W(DATA_W), .MAX_LOG2(MAX_LOG2)) i_sma_ctrl (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_enable       (enable),
		.i_window       (window),
		.i_window_wr    (window_wr),
		.i_sample_valid (i_sample_valid),
		.i_sample       (i_sample),
		.o_sample_ready (o_sample_ready),
		.o_busy         (busy),
		.hist           (hist.ctrl)
	);

	sma_history #(.DATA_W(DATA_W), .MAX_LOG2(MAX_LOG2)) i_sma_history (
		.i_clk (i_clk),
		.mem   (hist.mem)
	);

	sma_accum #(.DATA_W(DATA_W), .MAX_LOG2(MAX_LOG2)) i_sma_accum (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_window    (window),
		.acc         (hist.acc),
		.o_avg_valid (o_avg_valid),
		.o_avg       (o_avg)
	);

endmodule

//--- test/tb_sma.sv
module tb_sma import sma_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ns;

	localparam int DATA_W = 32;
	localparam int MAX_LOG2 = 4;
	// run length budget
	localparam int N_APB = 60;
	localparam int N_SAMPLES = 400;
	localparam int N_CLEARS = 10;
	localparam int LIMIT = N_APB * 3 + N_SAMPLES * 2 + N_CLEARS * 16 + 200;

	logic i_clk;
	logic i_rst_n;
	logic i_psel;
	logic i_penable;
	logic i_pwrite;
	logic [SMA_APB_AW-1:0] i_paddr;
	logic [DATA_W-1:0] i_pwdata;
	logic [DATA_W-1:0] o_prdata;
	logic o_pready;
	logic o_pslverr;
	logic i_sample_valid;
	logic signed [DATA_W-1:0] i_sample;
	logic o_sample_ready;
	logic o_avg_valid;
	logic signed [DATA_W-1:0] o_avg;

	// reference model state
	longint hist [1 << MAX_LOG2];
	longint sum;
	int ptr;
	int model_k;
	bit pending;
	bit running;
	logic [DATA_W-1:0] exp_avg;

	int errors = 0;
	int cycles = 0;
	logic [31:0] rng_state = 32'd25;
	logic [DATA_W-1:0] rd;
	logic err;

	sma_top #(.DATA_W(DATA_W), .MAX_LOG2(MAX_LOG2)) i_sma_top (.*);

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic compare(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("error: %0t %s = %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic clear_model(input int k);
		foreach (hist[i])
			hist[i] = 0;
		sum = 0;
		ptr = 0;
		model_k = k;
	endtask

	// expected result follows each accepting edge by one cycle
	always @(negedge i_clk) begin
		if (running) begin
			compare("o_avg_valid", o_avg_valid, pending);
			if (pending)
				compare("o_avg", o_avg, exp_avg);
			pending = i_sample_valid && o_sample_ready;
			if (pending) begin
				sum = sum + longint'(i_sample) - hist[ptr];
				hist[ptr] = longint'(i_sample);
				ptr = (ptr + 1) % (1 << model_k);
				exp_avg = DATA_W'(sum >>> model_k);
			end
		end
	end

	always @(posedge i_clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("timeout: run went past %0d cycles", LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic e);
		@(posedge i_clk);
		i_psel <= 1'b1;
		i_penable <= 1'b0;
		i_pwrite <= 1'b1;
		i_paddr <= addr;
		i_pwdata <= data;
		@(posedge i_clk);
		i_penable <= 1'b1;
		@(negedge i_clk);
		e = o_pslverr;
		compare("o_pready", o_pready, 1);
		@(posedge i_clk);
		i_psel <= 1'b0;
		i_penable <= 1'b0;
		i_pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic e);
		@(posedge i_clk);
		i_psel <= 1'b1;
		i_penable <= 1'b0;
		i_pwrite <= 1'b0;
		i_paddr <= addr;
		@(posedge i_clk);
		i_penable <= 1'b1;
		@(negedge i_clk);
		data = o_prdata;
		e = o_pslverr;
		@(posedge i_clk);
		i_psel <= 1'b0;
		i_penable <= 1'b0;
	endtask

	task automatic drive_samples(input int n);
		logic [31:0] r;
		repeat (n) begin
			r = next_rand();
			// random one-cycle gap
			if (r[16]) begin
				@(posedge i_clk);
				i_sample_valid <= 1'b0;
			end
			@(posedge i_clk);
			i_sample_valid <= 1'b1;
			i_sample <= next_rand();
		end
		@(posedge i_clk);
		i_sample_valid <= 1'b0;
	endtask

	// samples offered while the filter must refuse them
	task automatic offer_blocked(input int n);
		repeat (n) begin
			@(posedge i_clk);
			i_sample_valid <= 1'b1;
			i_sample <= next_rand();
			@(negedge i_clk);
			compare("o_sample_ready", o_sample_ready, 0);
		end
		@(posedge i_clk);
		i_sample_valid <= 1'b0;
	endtask

	task automatic wait_ready();
		int n = 0;
		@(negedge i_clk);
		while (!o_sample_ready && n < 40) begin
			@(negedge i_clk);
			n++;
		end
		if (!o_sample_ready) begin
			errors++;
			$display("sample ready never rose after the window write");
		end
	endtask

	task automatic set_window(input int k);
		apb_write(REG_WINDOW, k, err);
		compare("o_pslverr", err, 0);
		clear_model((k > MAX_LOG2) ? MAX_LOG2 : k);
		@(posedge i_clk);
		offer_blocked(3);
		apb_read(REG_STATUS, rd, err);
		compare("busy", rd, 1);
		apb_read(REG_WINDOW, rd, err);
		compare("window", rd, model_k);
		wait_ready();
	endtask

	initial begin
		int n;
		i_rst_n = 1'b0;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = '0;
		i_pwdata = '0;
		i_sample_valid = 1'b0;
		i_sample = '0;
		running = 1'b0;
		pending = 1'b0;
		exp_avg = '0;
		clear_model(0);
		repeat (10) @(posedge i_clk);
		i_rst_n <= 1'b1;
		running = 1'b1;
		@(negedge i_clk);
		compare("o_sample_ready", o_sample_ready, 0);
		apb_read(REG_STATUS, rd, err);
		compare("busy", rd, 1);
		apb_read(REG_CTRL, rd, err);
		compare("ctrl", rd, 0);
		apb_read(REG_WINDOW, rd, err);
		compare("window", rd, 0);
		n = 0;
		while (rd[0] !== 1'b0 || n == 0) begin
			apb_read(REG_STATUS, rd, err);
			n++;
			if (n > 10) begin
				errors++;
				$display("first clear after reset never finished");
				break;
			end
		end

		apb_write(REG_CTRL, 1, err);
		set_window(3);
		drive_samples(200);
		apb_read(REG_AVG, rd, err);
		compare("avg", rd, exp_avg);
		set_window(2);
		drive_samples(20);
		set_window(4);
		drive_samples(40);
		set_window(9);
		drive_samples(10);
		set_window(0);
		drive_samples(20);
		repeat (3) begin
			set_window(int'((next_rand() >> 16) % 5));
			drive_samples(16);
		end

		// enable off holds the result
		apb_write(REG_CTRL, 0, err);
		offer_blocked(5);
		apb_read(REG_AVG, rd, err);
		compare("avg", rd, exp_avg);
		apb_write(REG_CTRL, 1, err);
		drive_samples(8);

		// 0x6 is not decoded
		apb_read(4'h6, rd, err);
		compare("o_pslverr", err, 1);
		apb_write(REG_STATUS, 1, err);
		compare("o_pslverr", err, 1);
		apb_write(REG_AVG, 32'h1234, err);
		compare("o_pslverr", err, 1);
		apb_read(REG_CTRL, rd, err);
		compare("ctrl", rd, 1);
		apb_read(REG_WINDOW, rd, err);
		compare("window", rd, model_k);
		apb_read(REG_AVG, rd, err);
		compare("avg", rd, exp_avg);

		repeat (2) @(posedge i_clk);
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- project.f
rtl/sma_pkg.sv
rtl/sma_hist_if.sv
rtl/sma_apb_regs.sv
rtl/sma_ctrl.sv
rtl/sma_history.sv
rtl/sma_accum.sv
rtl/sma_top.sv
test/tb_sma.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the moving-average testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module tb_sma --Mdir obj_dir -o tb_sma_sim; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/tb_sma_sim > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation exited with an error"
	exit 1
fi

cat "$LOG"

if grep -qx "Done: no errors" "$LOG"; then
	exit 0
fi
exit 1
